//--- dv/opm_cart_checker.sv
// ---------------------------------------------------------------------
// Watches the cartridge outputs on the rising clock edge and compares
// them with the values the testbench expects at that moment.
// ---------------------------------------------------------------------
`default_nettype none

module opm_cart_checker (
	input  wire         clk,
	input  wire  [7:0]  i_rdata,
	input  wire         i_rdata_en,
	input  wire  [16:0] i_sound_out,
	input  wire         i_int_n,
	input  wire         i_rd_expect,	// Read op in progress
	input  wire         i_rd_compare,	// Read data must match
	input  wire  [7:0]  i_rd_data,
	input  wire         i_snd_check,	// Compare mix this edge
	input  wire  [16:0] i_snd_data,
	input  wire         i_irq_check,	// Compare irq line this edge
	input  wire         i_irq_level,
	output int          o_mismatches
);
	int errors = 0;

	assign o_mismatches = errors;

	always @(posedge clk) begin
		if (i_rdata_en === 1'b1) begin
			if (!i_rd_expect) begin
				errors++;
				$display("mismatch at %0t: o_rdata_en high with no read pending", $time);
			end else if (i_rd_compare && i_rdata !== i_rd_data) begin
				errors++;
				$display("mismatch at %0t: o_rdata %02h, expected %02h",
					$time, i_rdata, i_rd_data);
			end
		end
		if (i_snd_check && i_sound_out !== i_snd_data) begin
			errors++;
			$display("mismatch at %0t: o_sound_out %05h, expected %05h",
				$time, i_sound_out, i_snd_data);
		end
		if (i_irq_check && i_int_n !== i_irq_level) begin
			errors++;
			$display("mismatch at %0t: o_int_n %0b, expected %0b",
				$time, i_int_n, i_irq_level);
		end
	end
endmodule

`default_nettype wire

//--- dv/opm_cart_patterns.txt
# columns: op, address or register number, value, slot select (hex)
# wr: reg to 3FF0 then value to 3FF1; rd/rdn/poll: read; irq: o_int_n; snd: o_sound_out
snd 0000 00000 1
irq 0000 1 1
rd 0080 4d 1
rd 0085 30 1
rd 0086 08 1
rd 0089 c9 1
rd 008f c9 1
rdn 0080 00 0
rdn c080 00 1
rd 3ff0 ff 1
wr 0020 34 1
wr 0021 12 1
wr 0022 00 1
wr 0023 80 1
snd 0000 19234 1
wr 0022 ff 1
snd 0000 19234 1
wr 0023 7f 1
snd 0000 09233 1
wr 0020 ff 1
wr 0021 7f 1
snd 0000 0fffe 1
wr 0020 00 1
wr 0021 80 1
snd 0000 1ffff 1
wr 0022 00 1
wr 0023 80 1
snd 0000 10000 1
wr 0010 f0 1
wr 0014 03 1
irq 0000 0 1
rd 3ff1 01 1
wr 0014 13 1
irq 0000 1 1
rd 3ff1 00 1
wr 0014 11 1
poll 3ff1 01 1
irq 0000 1 1

//--- dv/tb_opm_cart.sv
// ---------------------------------------------------------------------
// Testbench for the FM cartridge. Runs the operations listed in
// dv/opm_cart_patterns.txt and needs the project root as working folder.
// Inputs change 1 time unit after the rising clock edge.
// ---------------------------------------------------------------------
`default_nettype none

module tb_opm_cart;
	logic        clk;
	logic        n_reset;
	logic        i_mclkpcen_n;
	logic        i_n_memreq;
	logic        i_n_sltsl;
	logic        i_n_wr;
	logic        i_n_rd;
	logic [15:0] i_address;
	logic [7:0]  i_wdata;
	logic [7:0]  o_rdata;
	logic        o_rdata_en;
	logic [16:0] o_sound_out;
	logic        o_int_n;

	logic        rd_expect;	// Expectations for the checker
	logic        rd_compare;
	logic [7:0]  rd_data;
	logic        snd_check;
	logic [16:0] snd_data;
	logic        irq_check;
	logic        irq_level;
	int          mismatches;
	int          failures = 0;	// Timeouts and pattern errors

	opm_cart_top i_dut (.*);

	opm_cart_checker u_checker (
		.clk          (clk),
		.i_rdata      (o_rdata),
		.i_rdata_en   (o_rdata_en),
		.i_sound_out  (o_sound_out),
		.i_int_n      (o_int_n),
		.i_rd_expect  (rd_expect),
		.i_rd_compare (rd_compare),
		.i_rd_data    (rd_data),
		.i_snd_check  (snd_check),
		.i_snd_data   (snd_data),
		.i_irq_check  (irq_check),
		.i_irq_level  (irq_level),
		.o_mismatches (mismatches)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		i_mclkpcen_n = 1'b1;
		forever begin
			@(posedge clk);
			#1 i_mclkpcen_n = ~i_mclkpcen_n;	// Enable every other clock
		end
	end

	// ------------------------------------------------------------------
	// Bus cycles
	// ------------------------------------------------------------------
	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic bus_idle;
		i_n_memreq = 1'b1;
		i_n_sltsl  = 1'b1;
		i_n_wr     = 1'b1;
		i_n_rd     = 1'b1;
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data, input logic sel);
		i_address  = addr;
		i_wdata    = data;
		i_n_sltsl  = !sel;
		i_n_memreq = 1'b0;
		i_n_wr     = 1'b0;	// One clock low is enough
		next_cycle();
		bus_idle();
		next_cycle();
	endtask

	task automatic wait_rdata_en(input logic level, input int limit);
		int n;
		n = 0;
		while (o_rdata_en !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (o_rdata_en !== level) begin
			failures++;
			$display("timeout at %0t: o_rdata_en did not go to %0b", $time, level);
		end
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic sel, input logic cmp,
		input logic [7:0] data, output logic [7:0] got);
		rd_expect  = 1'b1;
		rd_compare = cmp;
		rd_data    = data;
		i_address  = addr;
		i_n_sltsl  = !sel;
		i_n_memreq = 1'b0;
		i_n_rd     = 1'b0;
		wait_rdata_en(1'b1, 8);
		got = o_rdata;
		next_cycle();
		bus_idle();
		wait_rdata_en(1'b0, 8);	// Data stays valid until here
		rd_expect = 1'b0;
	endtask

	// Unmapped or deselected read where the checker flags any read enable
	task automatic silent_read(input logic [15:0] addr, input logic sel);
		i_address  = addr;
		i_n_sltsl  = !sel;
		i_n_memreq = 1'b0;
		i_n_rd     = 1'b0;
		repeat (6) next_cycle();
		bus_idle();
		repeat (3) next_cycle();
	endtask

	task automatic wait_int_low(input int limit);
		int n;
		n = 0;
		while (o_int_n !== 1'b0 && n < limit) begin
			next_cycle();
			n++;
		end
		if (o_int_n !== 1'b0) begin
			failures++;
			$display("timeout at %0t: o_int_n never went low", $time);
		end
	endtask

	// ------------------------------------------------------------------
	// Pattern operations
	// ------------------------------------------------------------------
	task automatic run_op(input string op, input logic [15:0] addr,
		input logic [16:0] value, input logic sel);
		logic [7:0] got;
		int         tries;
		if (op == "wr") begin
			bus_write(16'h3FF0, addr[7:0], sel);	// Register number
			bus_write(16'h3FF1, value[7:0], sel);
		end else if (op == "rd") begin
			bus_read(addr, sel, 1'b1, value[7:0], got);
		end else if (op == "rdn") begin
			silent_read(addr, sel);
		end else if (op == "poll") begin
			tries = 0;
			got   = ~value[7:0];
			while (got !== value[7:0] && tries < 200) begin
				bus_read(addr, sel, 1'b0, value[7:0], got);
				tries++;
			end
			if (got !== value[7:0]) begin
				failures++;
				$display("timeout at %0t: %04h never read back %02h",
					$time, addr, value[7:0]);
			end
		end else if (op == "irq") begin
			if (!value[0]) begin
				wait_int_low(4000);
			end
			irq_check = 1'b1;
			irq_level = value[0];
			next_cycle();
			irq_check = 1'b0;
		end else if (op == "snd") begin
			next_cycle();	// Mix lands 2 clocks after the strobe
			snd_check = 1'b1;
			snd_data  = value;
			next_cycle();
			snd_check = 1'b0;
		end else begin
			failures++;
			$display("unknown pattern operation %s", op);
		end
	endtask

	initial begin
		string line;
		string op;
		int    fd;
		int    n;
		logic [15:0] addr;
		logic [16:0] value;
		logic        sel;
		bus_idle();
		i_address  = 16'h0000;
		i_wdata    = 8'h00;
		rd_expect  = 1'b0;
		rd_compare = 1'b0;
		rd_data    = 8'h00;
		snd_check  = 1'b0;
		snd_data   = 17'h00000;
		irq_check  = 1'b0;
		irq_level  = 1'b1;
		n_reset    = 1'b0;
		repeat (16) @(posedge clk);
		#1 n_reset = 1'b1;
		next_cycle();

		fd = $fopen("dv/opm_cart_patterns.txt", "r");
		if (fd == 0) begin
			failures++;
			$display("could not open the pattern file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n    = $fgets(line, fd);
				if (line.len() == 0 || line[0] == "#") begin
					continue;	// Blank or comment line
				end
				n = $sscanf(line, "%s %h %h %h", op, addr, value, sel);
				if (n != 4) begin
					failures++;
					$display("pattern line not understood: %s", line);
				end else begin
					run_op(op, addr, value, sel);
				end
			end
			$fclose(fd);
		end

		repeat (2) next_cycle();
		$display("mismatches %0d, other errors %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FM cartridge testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_opm_cart \
	-f sources.f \
	-o tb_opm_cart

./obj_dir/tb_opm_cart > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1

//--- sources.f
src/opm_cart_pkg.sv
src/opm_bus_if.sv
src/opm_bus_decode.sv
src/opm_reg_execute.sv
src/opm_result.sv
src/opm_cart_top.sv
dv/opm_cart_checker.sv
dv/tb_opm_cart.sv

//--- src/opm_bus_decode.sv
// ---------------------------------------------------------------------
// Slot bus front end. All bus inputs pass one register stage.
// The host must hold address, data and selects stable while a
// strobe is low. No wait states are ever requested.
// ---------------------------------------------------------------------
`default_nettype none

module opm_bus_decode
	import opm_cart_pkg::*;
(
	input  wire        clk,
	input  wire        n_reset,
	input  wire        i_n_memreq,
	input  wire        i_n_sltsl,
	input  wire        i_n_wr,
	input  wire        i_n_rd,
	input  bus_addr_u  i_address,
	input  wire  [7:0] i_wdata,
	opm_bus_if.decoder o_bus
);
	logic       ff_n_memreq;
	logic       ff_n_sltsl;
	logic       ff_n_wr;
	logic       ff_n_rd;
	logic       ff_n_wr_prev;	// Last cycle's write level
	logic       ff_n_rd_prev;	// Last cycle's read level
	bus_addr_u  ff_address;
	logic [7:0] ff_wdata;

	logic w_sel;
	logic w_port_hit;
	logic w_rom_hit;
	logic w_page0;

	// ------------------------------------------------------------------
	// Input stage
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_n_memreq  <= 1'b1;	// Bus idle
			ff_n_sltsl   <= 1'b1;
			ff_n_wr      <= 1'b1;
			ff_n_rd      <= 1'b1;
			ff_n_wr_prev <= 1'b1;
			ff_n_rd_prev <= 1'b1;
		end else begin
			ff_n_memreq  <= i_n_memreq;
			ff_n_sltsl   <= i_n_sltsl;
			ff_n_wr      <= i_n_wr;
			ff_n_rd      <= i_n_rd;
			ff_n_wr_prev <= ff_n_wr;
			ff_n_rd_prev <= ff_n_rd;
		end
	end

	always_ff @(posedge clk) begin
		ff_address <= i_address;	// Payload only
		ff_wdata   <= i_wdata;
	end

	// ------------------------------------------------------------------
	// Access classification
	// ------------------------------------------------------------------
	assign w_sel      = !ff_n_sltsl && !ff_n_memreq;
	assign w_port_hit = w_sel && (ff_address.port_view.base == C_PORT_BASE[15:1]);
	assign w_rom_hit  = w_sel && (ff_address.rom_view.page == C_ROM_BASE[15:4]);
	assign w_page0    = (ff_address.rom_view.page[11:10] == 2'b00);	// A15:A14 low

	// Falling edges give single-cycle strobes
	assign o_bus.wr_stb    = w_port_hit && !ff_n_wr && ff_n_wr_prev;
	assign o_bus.rd_stb    = w_port_hit && w_page0 && !ff_n_rd && ff_n_rd_prev;
	assign o_bus.rom_rd    = w_rom_hit && w_page0 && !ff_n_rd;
	assign o_bus.port_rd   = w_port_hit && w_page0 && !ff_n_rd;
	assign o_bus.a0        = ff_address.port_view.sel;
	assign o_bus.wdata     = ff_wdata;
	assign o_bus.rom_index = ff_address.rom_view.index;
endmodule

`default_nettype wire

//--- src/opm_bus_if.sv
// ---------------------------------------------------------------------
// Decoded slot bus traffic. Strobes are one clock wide; the rd
// levels stay high for the whole read.
// ---------------------------------------------------------------------
`default_nettype none

interface opm_bus_if;
	logic       wr_stb;		// Port write, one cycle
	logic       rd_stb;		// Port read start, one cycle
	logic       rom_rd;		// ROM read in progress
	logic       port_rd;	// Port read in progress
	logic       a0;			// Port select
	logic [7:0] wdata;
	logic [3:0] rom_index;

	modport decoder (
		output wr_stb, rd_stb, rom_rd, port_rd, a0, wdata, rom_index
	);

	modport exec (
		input wr_stb, a0, wdata
	);

	modport result (
		input rd_stb, rom_rd, port_rd, a0, rom_index
	);
endinterface

`default_nettype wire

//--- src/opm_cart_pkg.sv
// ---------------------------------------------------------------------
// Shared constants for the FM sound cartridge.
// The ROM table and the register numbers follow the cartridge's
// identification layout. Bus addresses are always 16 bits.
// ---------------------------------------------------------------------
`default_nettype none

package opm_cart_pkg;

	// ------------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------------
	localparam logic [15:0] C_PORT_BASE = 16'h3FF0;	// A0 picks latch or data
	localparam logic [15:0] C_ROM_BASE  = 16'h0080;	// 16-byte ID window

	// ------------------------------------------------------------------
	// Identification ROM
	// ------------------------------------------------------------------
	localparam logic [7:0] C_ROM_FILL   = 8'hC9;	// Bytes past the table
	localparam int         C_ROM_ID_LEN = 9;
	localparam logic [7:0] C_ROM_ID [C_ROM_ID_LEN] = '{
		8'h4D,	// M
		8'h43,	// C
		8'h48,	// H
		8'h46,	// F
		8'h4D,	// M
		8'h30,	// 0
		8'h08,	// Serial number
		8'h00,	// Chip type
		8'h00	// Software version
	};

	// ------------------------------------------------------------------
	// Chip register numbers
	// ------------------------------------------------------------------
	localparam logic [7:0] C_REG_TIMER    = 8'h10;	// Timer load value
	localparam logic [7:0] C_REG_CTRL     = 8'h14;	// Run, irq enable, flag clear
	localparam logic [7:0] C_REG_LVL_L_LO = 8'h20;
	localparam logic [7:0] C_REG_LVL_L_HI = 8'h21;
	localparam logic [7:0] C_REG_LVL_R_LO = 8'h22;
	localparam logic [7:0] C_REG_LVL_R_HI = 8'h23;

	localparam int C_TIMER_PRESCALE = 16;	// Clock enables per count
	localparam int C_PRESCALE_W     = $clog2(C_TIMER_PRESCALE);

	// Bus address seen either as ROM page/index or as port base/select
	typedef union packed {
		struct packed {
			logic [11:0] page;
			logic [3:0]  index;
		} rom_view;
		struct packed {
			logic [14:0] base;
			logic        sel;
		} port_view;
	} bus_addr_u;

endpackage

`default_nettype wire

//--- src/opm_cart_top.sv
// ---------------------------------------------------------------------
// FM sound cartridge top. Chip ports at 3FF0h/3FF1h, ID ROM at
// 0080h-008Fh. Plain slot bus pins, no wait states.
// o_sound_out is the 17-bit sum of left and right levels.
// ---------------------------------------------------------------------
`default_nettype none

module opm_cart_top (
	input  wire         clk,
	input  wire         n_reset,
	input  wire         i_mclkpcen_n,	// Master clock enable, active low
	input  wire         i_n_memreq,
	input  wire         i_n_sltsl,
	input  wire         i_n_wr,
	input  wire         i_n_rd,
	input  wire  [15:0] i_address,
	input  wire  [7:0]  i_wdata,
	output logic [7:0]  o_rdata,
	output logic        o_rdata_en,
	output logic [16:0] o_sound_out,
	output logic        o_int_n
);
	logic        [7:0]  w_status;
	logic signed [15:0] w_level_l;
	logic signed [15:0] w_level_r;

	opm_bus_if u_bus ();

	// ------------------------------------------------------------------
	// Bus decode
	// ------------------------------------------------------------------
	opm_bus_decode u_decode (
		.clk        (clk),
		.n_reset    (n_reset),
		.i_n_memreq (i_n_memreq),
		.i_n_sltsl  (i_n_sltsl),
		.i_n_wr     (i_n_wr),
		.i_n_rd     (i_n_rd),
		.i_address  (i_address),	// Viewed as ROM/port union inside
		.i_wdata    (i_wdata),
		.o_bus      (u_bus.decoder)
	);

	// ------------------------------------------------------------------
	// Chip register model
	// ------------------------------------------------------------------
	opm_reg_execute u_execute (
		.clk          (clk),
		.n_reset      (n_reset),
		.i_mclkpcen_n (i_mclkpcen_n),
		.i_bus        (u_bus.exec),
		.o_status     (w_status),
		.o_level_l    (w_level_l),
		.o_level_r    (w_level_r),
		.o_int_n      (o_int_n)
	);

	// ------------------------------------------------------------------
	// Read data and mix
	// ------------------------------------------------------------------
	opm_result u_result (
		.clk         (clk),
		.n_reset     (n_reset),
		.i_bus       (u_bus.result),
		.i_status    (w_status),
		.i_level_l   (w_level_l),
		.i_level_r   (w_level_r),
		.o_rdata     (o_rdata),
		.o_rdata_en  (o_rdata_en),
		.o_sound_out (o_sound_out)
	);
endmodule

`default_nettype wire

//--- src/opm_reg_execute.sv
// ---------------------------------------------------------------------
// Reduced register model of the FM chip: address latch, one
// reloading timer with flag and interrupt, two 16-bit levels.
// No synthesis, envelopes or busy status are modelled.
// ---------------------------------------------------------------------
`default_nettype none

module opm_reg_execute
	import opm_cart_pkg::*;
(
	input  wire                clk,
	input  wire                n_reset,
	input  wire                i_mclkpcen_n,	// Master clock enable, active low
	opm_bus_if.exec            i_bus,
	output logic        [7:0]  o_status,
	output logic signed [15:0] o_level_l,
	output logic signed [15:0] o_level_r,
	output logic               o_int_n
);
	logic [7:0] ff_reg_addr;	// Address latch
	logic [7:0] ff_timer_load;
	logic       ff_run;
	logic       ff_irq_en;
	logic [7:0] ff_lvl_l_lo;	// Staged low bytes
	logic [7:0] ff_lvl_r_lo;
	logic [15:0] ff_level_l;
	logic [15:0] ff_level_r;

	logic [C_PRESCALE_W-1:0] ff_prescale;
	logic [7:0]              ff_count;
	logic                    ff_flag;

	logic w_data_wr;
	logic w_flag_clr;
	logic w_tick;
	logic w_overflow;

	assign w_data_wr  = i_bus.wr_stb && i_bus.a0;
	assign w_flag_clr = w_data_wr && (ff_reg_addr == C_REG_CTRL) && i_bus.wdata[4];

	// ------------------------------------------------------------------
	// Register writes
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_reg_addr   <= 8'h00;
			ff_timer_load <= 8'h00;
			ff_run        <= 1'b0;
			ff_irq_en     <= 1'b0;
			ff_lvl_l_lo   <= 8'h00;
			ff_lvl_r_lo   <= 8'h00;
			ff_level_l    <= 16'h0000;
			ff_level_r    <= 16'h0000;
		end else if (i_bus.wr_stb) begin
			if (!i_bus.a0) begin
				ff_reg_addr <= i_bus.wdata;	// Port 0 selects register
			end else begin
				case (ff_reg_addr)
					C_REG_TIMER: ff_timer_load <= i_bus.wdata;
					C_REG_CTRL: begin
						ff_run    <= i_bus.wdata[0];
						ff_irq_en <= i_bus.wdata[1];
					end
					C_REG_LVL_L_LO: ff_lvl_l_lo <= i_bus.wdata;	// Held until HI
					C_REG_LVL_L_HI: ff_level_l  <= {i_bus.wdata, ff_lvl_l_lo};
					C_REG_LVL_R_LO: ff_lvl_r_lo <= i_bus.wdata;
					C_REG_LVL_R_HI: ff_level_r  <= {i_bus.wdata, ff_lvl_r_lo};
					default: ;	// Other registers ignored
				endcase
			end
		end
	end

	// ------------------------------------------------------------------
	// Timer
	// ------------------------------------------------------------------
	assign w_tick     = ff_run && !i_mclkpcen_n &&
		(ff_prescale == C_PRESCALE_W'(C_TIMER_PRESCALE - 1));
	assign w_overflow = w_tick && (ff_count == 8'hFF);

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_prescale <= '0;
			ff_count    <= 8'h00;
		end else if (!ff_run) begin
			ff_prescale <= '0;
			ff_count    <= ff_timer_load;	// Start from load value
		end else if (!i_mclkpcen_n) begin
			if (w_tick) begin
				ff_prescale <= '0;
				ff_count    <= w_overflow ? ff_timer_load : ff_count + 8'h01;
			end else begin
				ff_prescale <= ff_prescale + 1'b1;
			end
		end
	end

	// Overflow wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_flag <= 1'b0;
		end else if (w_overflow) begin
			ff_flag <= 1'b1;
		end else if (w_flag_clr) begin
			ff_flag <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// Outputs
	// ------------------------------------------------------------------
	assign o_status  = {7'b0000000, ff_flag};	// Bit 0 timer flag
	assign o_level_l = ff_level_l;
	assign o_level_r = ff_level_r;
	assign o_int_n   = !(ff_flag && ff_irq_en);
endmodule

`default_nettype wire

//--- src/opm_result.sv
// ---------------------------------------------------------------------
// Read data path and stereo mix. Read enable trails the decoded
// read by two clocks. Status is sampled once at read start.
// ---------------------------------------------------------------------
`default_nettype none

module opm_result
	import opm_cart_pkg::*;
(
	input  wire                clk,
	input  wire                n_reset,
	opm_bus_if.result          i_bus,
	input  wire         [7:0]  i_status,
	input  wire  signed [15:0] i_level_l,
	input  wire  signed [15:0] i_level_r,
	output logic        [7:0]  o_rdata,
	output logic               o_rdata_en,
	output logic        [16:0] o_sound_out
);
	logic [7:0] ff_rom_byte;
	logic [7:0] ff_status;		// Snapshot at read start
	logic       ff_rd_rom;
	logic       ff_rd_status;
	logic       ff_rd_any;

	// ------------------------------------------------------------------
	// First stage with lookup and read class
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (int'(i_bus.rom_index) < C_ROM_ID_LEN) begin
			ff_rom_byte <= C_ROM_ID[i_bus.rom_index];
		end else begin
			ff_rom_byte <= C_ROM_FILL;
		end
		if (i_bus.rd_stb) begin
			ff_status <= i_status;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_rd_rom    <= 1'b0;
			ff_rd_status <= 1'b0;
			ff_rd_any    <= 1'b0;
		end else begin
			ff_rd_rom    <= i_bus.rom_rd;
			ff_rd_status <= i_bus.port_rd && i_bus.a0;
			ff_rd_any    <= i_bus.rom_rd || i_bus.port_rd;
		end
	end

	// ------------------------------------------------------------------
	// Second stage with output registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (ff_rd_rom) begin
			o_rdata <= ff_rom_byte;
		end else if (ff_rd_status) begin
			o_rdata <= ff_status;
		end else begin
			o_rdata <= 8'hFF;	// Port 0 reads float high
		end
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			o_rdata_en  <= 1'b0;
			o_sound_out <= 17'h00000;
		end else begin
			o_rdata_en  <= ff_rd_any;
			o_sound_out <= {i_level_l[15], i_level_l} + {i_level_r[15], i_level_r};
		end
	end
endmodule

`default_nettype wire
